/* flist.f */
+incdir+rtl
rtl/dpPkg.sv
rtl/dpStageIf.sv
rtl/intAlu.sv
rtl/regFile.sv
rtl/fetchDecode.sv
rtl/executeStage.sv
rtl/memWbStage.sv
rtl/pipeDatapath.sv
tests/dp_properties.sv
tests/dpTb.sv

/* Makefile */
sim:
	verilator --binary --timing --assert --top-module dpTb -f flist.f -o VdpTb
	./obj_dir/VdpTb > sim.log; cat sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* tests/dpTb.sv */
// Directed testbench for the pipelined datapath
// Plays controller and memories, checks PC, decode fields, ALU, forwarding, redirect, flush
`timescale 1ns/1ps
`include "dp_settings.svh"

module dpTb;
    import dpPkg::*;

    localparam int SLOTS = 8;
    localparam instrWordT NOP = `DP_NOP_INSTR;

    logic clk = 1'b0;
    logic reset, stallF_i, stallD_i, flushD_i, flushE_i, pcSrcE_i, regWriteW_i;
    instrWordT  instrF_i;
    immSrcT     immSrcD_i;
    srcBSelT    aluSrcE_i;
    aluCtrlT    aluControlE_i;
    forwardSelT forwardAE_i, forwardBE_i;
    dataWordT   readDataM_i, pcF_o, aluResultM_o, writeDataM_o;
    resultSrcT  resultSrcM_i, resultSrcW_i;
    logic [6:0] op_o;
    logic [2:0] funct3_o;
    logic       funct7b5_o, zeroE_o;
    regAddrT    rs1D_o, rs2D_o, rs1E_o, rs2E_o, rdE_o, rdM_o, rdW_o;
    int         errors = 0;

    // One entry per issued instruction, with its controls and expected results
    instrWordT  instrQ [SLOTS];
    immSrcT     immQ [SLOTS];
    srcBSelT    srcBQ [SLOTS];
    aluCtrlT    aluQ [SLOTS];
    forwardSelT fwdAQ [SLOTS];
    forwardSelT fwdBQ [SLOTS];
    logic       pcSrcQ [SLOTS];
    logic       wbEnQ [SLOTS];
    logic       chkAlu [SLOTS];
    logic       chkWd [SLOTS];
    dataWordT   expAlu [SLOTS];
    dataWordT   expWd [SLOTS];
    dataWordT   expPcOff [SLOTS];

    pipeDatapath i_pipeDatapath (.*);

    bind pipeDatapath dp_properties i_dpProperties (
        .clk(clk), .reset(reset), .stallF_i(stallF_i), .flushE_i(flushE_i),
        .pcF_o(pcF_o), .rdE_o(rdE_o)
    );

    always #50 clk = ~clk;

    function automatic dataWordT sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic instrWordT encI(input logic [11:0] im, input regAddrT rs1, input regAddrT rd);
        return {im, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic instrWordT encR(input logic f7b5, input regAddrT rs2, input regAddrT rs1,
                                       input regAddrT rd);
        return {1'b0, f7b5, 5'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic instrWordT encS(input logic [11:0] im, input regAddrT rs2, input regAddrT rs1);
        return {im[11:5], rs2, rs1, 3'b010, im[4:0], 7'b0100011};
    endfunction

    function automatic instrWordT encB(input logic [12:0] im, input regAddrT rs2, input regAddrT rs1);
        return {im[12], im[10:5], rs2, rs1, 3'b000, im[4:1], im[11], 7'b1100011};
    endfunction

    task automatic checkWord(input string name, input dataWordT got, input dataWordT exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkReg(input string name, input regAddrT got, input regAddrT exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic clearSlots();
        for (int i = 0; i < SLOTS; i++) begin
            instrQ[i] = NOP;
            immQ[i]   = immI;
            srcBQ[i]  = srcImm;
            aluQ[i]   = aluAdd;
            fwdAQ[i]  = regFile;
            fwdBQ[i]  = regFile;
            pcSrcQ[i] = 1'b0;
            wbEnQ[i]  = 1'b0;
            chkAlu[i] = 1'b0;
            chkWd[i]  = 1'b0;
            expPcOff[i] = 'x; // No redirect check unless set
        end
    endtask

    // Each slot is fetched at c, decoded c+1, executed c+2, in memory c+3, writeback c+4
    task automatic runSlots(input int n);
        dataWordT pcAtFetch [SLOTS];
        int s;
        for (int c = 0; c < n + 4; c++) begin
            @(negedge clk);
            s = c - 3;
            if (s >= 0 && s < n) begin
                if (chkAlu[s]) checkWord("aluResultM_o", aluResultM_o, expAlu[s]);
                if (chkWd[s]) checkWord("writeDataM_o", writeDataM_o, expWd[s]);
                if (pcSrcQ[s]) checkWord("pcF_o", pcF_o, pcAtFetch[s] + expPcOff[s]);
            end
            instrF_i = (c < n) ? instrQ[c] : NOP;
            if (c < n) pcAtFetch[c] = pcF_o;
            s = c - 1;
            immSrcD_i = (s >= 0 && s < n) ? immQ[s] : immI;
            s = c - 2;
            if (s >= 0 && s < n) begin
                aluSrcE_i     = srcBQ[s];
                aluControlE_i = aluQ[s];
                forwardAE_i   = fwdAQ[s];
                forwardBE_i   = fwdBQ[s];
                pcSrcE_i      = pcSrcQ[s];
            end else begin
                pcSrcE_i = 1'b0;
            end
            s = c - 4;
            regWriteW_i = (s >= 0 && s < n) ? wbEnQ[s] : 1'b0;
        end
        @(negedge clk);
        regWriteW_i = 1'b0;
        pcSrcE_i    = 1'b0;
        forwardAE_i = regFile;
        forwardBE_i = regFile;
    endtask

    task automatic resetAndStepTest();
        dataWordT expPc;
        expPc = `DP_PC_START;
        checkWord("pcF_o", pcF_o, expPc);
        checkReg("rdE_o", rdE_o, '0);
        checkReg("rdM_o", rdM_o, '0);
        checkReg("rdW_o", rdW_o, '0);
        checkWord("aluResultM_o", aluResultM_o, '0);
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            expPc = expPc + 32'd4;
            checkWord("pcF_o", pcF_o, expPc);
        end
        stallF_i = 1'b1;
        @(negedge clk);
        checkWord("pcF_o", pcF_o, expPc); // Held by the stall
        stallF_i = 1'b0;
    endtask

    task automatic immAluTest();
        logic [11:0] im;
        im = 12'($urandom);
        clearSlots();
        instrQ[0] = encI(im, 5'd0, 5'd5);
        chkAlu[0] = 1'b1;
        expAlu[0] = sext12(im);
        instrQ[1] = encI(im, 5'd0, 5'd6);
        aluQ[1]   = aluSub;
        chkAlu[1] = 1'b1;
        expAlu[1] = 32'd0 - sext12(im);
        instrQ[2] = encI(im, 5'd0, 5'd7);
        aluQ[2]   = aluSlt;
        chkAlu[2] = 1'b1;
        expAlu[2] = (im[11] == 1'b0 && im != 0) ? 32'd1 : 32'd0; // 0 < imm
        runSlots(3);
    endtask

    task automatic writeReadTest();
        logic [11:0] v, off;
        v   = 12'($urandom);
        off = 12'($urandom);
        clearSlots();
        instrQ[0] = encI(v, 5'd0, 5'd7);
        wbEnQ[0]  = 1'b1;
        instrQ[1] = encI(v, 5'd0, 5'd0); // Write to x0, lands while slot 4 reads x0
        wbEnQ[1]  = 1'b1;
        instrQ[3] = encS(off, 5'd7, 5'd0); // Decoded in the write cycle
        immQ[3]   = immS;
        chkAlu[3] = 1'b1;
        expAlu[3] = sext12(off);
        chkWd[3]  = 1'b1;
        expWd[3]  = sext12(v);
        instrQ[4] = encS(off, 5'd0, 5'd0);
        immQ[4]   = immS;
        chkWd[4]  = 1'b1;
        expWd[4]  = '0;
        runSlots(5);
    endtask

    task automatic forwardTest();
        logic [11:0] a, b;
        a = 12'($urandom);
        b = 12'($urandom);
        clearSlots();
        instrQ[0] = encI(a, 5'd0, 5'd1);
        instrQ[1] = encI(b, 5'd0, 5'd2);
        instrQ[2] = encR(1'b0, 5'd1, 5'd2, 5'd3);
        srcBQ[2]  = srcReg;
        fwdAQ[2]  = fromMem; // x2 sits in memory
        fwdBQ[2]  = fromWb;  // x1 sits in writeback
        chkAlu[2] = 1'b1;
        expAlu[2] = sext12(a) + sext12(b);
        runSlots(3);
    endtask

    task automatic redirectTest();
        logic [12:0] off;
        off = {1'b0, 8'($urandom), 4'b0000};
        clearSlots();
        instrQ[0]   = encB(off, 5'd0, 5'd0);
        immQ[0]     = immB;
        srcBQ[0]    = srcReg;
        aluQ[0]     = aluSub;
        pcSrcQ[0]   = 1'b1;
        expPcOff[0] = {{19{off[12]}}, off};
        runSlots(1);
    endtask

    task automatic flushTest();
        @(negedge clk);
        instrF_i = encR(1'b0, 5'd2, 5'd1, 5'd4);
        flushD_i = 1'b1;
        @(negedge clk);
        flushD_i = 1'b0;
        checkWord("op_o", dataWordT'(op_o), dataWordT'(NOP[6:0]));
        instrF_i = encI(12'h123, 5'd0, 5'd9);
        @(negedge clk);
        instrF_i      = NOP;
        flushE_i      = 1'b1;
        aluSrcE_i     = srcImm;
        aluControlE_i = aluOr;
        @(negedge clk);
        flushE_i = 1'b0;
        checkReg("rdE_o", rdE_o, '0);
        checkFlag("zeroE_o", zeroE_o, 1'b1); // Cleared operands and immediate
        @(negedge clk);
        checkReg("rdM_o", rdM_o, '0);
        @(negedge clk);
        checkReg("rdW_o", rdW_o, '0);
    endtask

    task automatic decodeFieldsTest();
        regAddrT   rs1;
        regAddrT   rs2;
        regAddrT   rd;
        instrWordT ins;
        rs1 = 5'($urandom);
        rs2 = ~rs1;
        rd  = 5'($urandom) | 5'd1;
        ins = {7'b0100000, rs2, rs1, 3'b101, rd, 7'b0110011}; // sra
        @(negedge clk);
        instrF_i  = ins;
        immSrcD_i = immI;
        @(negedge clk);
        instrF_i = NOP;
        checkWord("op_o", dataWordT'(op_o), 32'h0000_0033);
        checkWord("funct3_o", dataWordT'(funct3_o), 32'd5);
        checkFlag("funct7b5_o", funct7b5_o, 1'b1);
        checkReg("rs1D_o", rs1D_o, rs1);
        checkReg("rs2D_o", rs2D_o, rs2);
        aluSrcE_i     = srcImm;
        aluControlE_i = aluOr;
        forwardAE_i   = regFile;
        @(negedge clk);
        checkReg("rs1E_o", rs1E_o, rs1);
        checkReg("rs2E_o", rs2E_o, rs2);
        checkReg("rdE_o", rdE_o, rd);
        checkFlag("zeroE_o", zeroE_o, 1'b0); // I-immediate holds funct7, so the OR is nonzero
        @(negedge clk);
        checkReg("rdM_o", rdM_o, rd);
        @(negedge clk);
        checkReg("rdW_o", rdW_o, rd);
    endtask

    initial begin
        void'($urandom(32'h05a8_af9a));
        reset = 1'b1;
        {stallF_i, stallD_i, flushD_i, flushE_i, pcSrcE_i, regWriteW_i} = '0;
        instrF_i      = NOP;
        immSrcD_i     = immI;
        aluSrcE_i     = srcImm;
        aluControlE_i = aluAdd;
        forwardAE_i   = regFile;
        forwardBE_i   = regFile;
        readDataM_i   = '0;
        resultSrcM_i  = aluOut;
        resultSrcW_i  = aluOut;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        resetAndStepTest();
        immAluTest();
        writeReadTest();
        forwardTest();
        redirectTest();
        flushTest();
        decodeFieldsTest();
        errors += i_pipeDatapath.i_dpProperties.failures;
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tests/dp_properties.sv */
// Assertions on reset, execute flush and fetch stall behavior
`timescale 1ns/1ps

module dp_properties (
    input logic            clk,
    input logic            reset,
    input logic            stallF_i,
    input logic            flushE_i,
    input dpPkg::dataWordT pcF_o,
    input dpPkg::regAddrT  rdE_o
);
    import dpPkg::*;

    int failures = 0; // Count of failed assertions

    // Execute register is cleared by reset
    resetClearsExecute: assert property (@(posedge clk) reset |=> rdE_o == '0)
        else begin
            $error("rdE_o not zero after reset");
            failures++;
        end

    flushClearsExecute: assert property (@(posedge clk) disable iff (reset)
        flushE_i |=> rdE_o == '0)
        else begin
            $error("rdE_o not zero after execute flush");
            failures++;
        end

    // Stalled fetch keeps its PC, redirect included
    stallHoldsPc: assert property (@(posedge clk) disable iff (reset)
        stallF_i |=> pcF_o == $past(pcF_o))
        else begin
            $error("pcF_o moved across a stalled edge");
            failures++;
        end

endmodule

/* rtl/pipeDatapath.sv */
// Five-stage RV32 integer datapath top level
// Connects front end, register file, execute and memory/writeback stages
`timescale 1ns/1ps

module pipeDatapath (
    input  logic               clk,
    input  logic               reset,
    input  logic               stallF_i,
    input  logic               stallD_i,
    input  logic               flushD_i,
    input  logic               flushE_i,
    input  logic               pcSrcE_i,
    input  dpPkg::instrWordT   instrF_i,
    input  dpPkg::immSrcT      immSrcD_i,
    input  dpPkg::srcBSelT     aluSrcE_i,
    input  dpPkg::aluCtrlT     aluControlE_i,
    input  dpPkg::forwardSelT  forwardAE_i,
    input  dpPkg::forwardSelT  forwardBE_i,
    input  dpPkg::dataWordT    readDataM_i,
    input  dpPkg::resultSrcT   resultSrcM_i,
    input  dpPkg::resultSrcT   resultSrcW_i,
    input  logic               regWriteW_i,
    output dpPkg::dataWordT    pcF_o,
    output dpPkg::dataWordT    aluResultM_o,
    output dpPkg::dataWordT    writeDataM_o,
    output logic [6:0]         op_o,
    output logic [2:0]         funct3_o,
    output logic               funct7b5_o,
    output dpPkg::regAddrT     rs1D_o,
    output dpPkg::regAddrT     rs2D_o,
    output dpPkg::regAddrT     rs1E_o,
    output dpPkg::regAddrT     rs2E_o,
    output dpPkg::regAddrT     rdE_o,
    output dpPkg::regAddrT     rdM_o,
    output dpPkg::regAddrT     rdW_o,
    output logic               zeroE_o
);
    import dpPkg::*;

    dataWordT pcTargetE; // Branch target from execute
    dataWordT rd1D;
    dataWordT rd2D;

    decExIf decEx ();
    exMemIf exMem ();
    wbIf    wb ();

    fetchDecode i_fetchDecode (
        .clk        (clk),
        .reset      (reset),
        .stallF_i   (stallF_i),
        .stallD_i   (stallD_i),
        .flushD_i   (flushD_i),
        .pcSrcE_i   (pcSrcE_i),
        .instrF_i   (instrF_i),
        .pcTargetE_i(pcTargetE),
        .immSrcD_i  (immSrcD_i),
        .rd1_i      (rd1D),
        .rd2_i      (rd2D),
        .pcF_o      (pcF_o),
        .op_o       (op_o),
        .funct3_o   (funct3_o),
        .funct7b5_o (funct7b5_o),
        .rs1D_o     (rs1D_o),
        .rs2D_o     (rs2D_o),
        .decEx      (decEx.src)
    );

    regFile i_regFile (
        .clk  (clk),
        .a1_i (rs1D_o),
        .a2_i (rs2D_o),
        .we_i (regWriteW_i),
        .rd1_o(rd1D),
        .rd2_o(rd2D),
        .wb   (wb.dst)
    );

    executeStage i_executeStage (
        .clk          (clk),
        .reset        (reset),
        .flushE_i     (flushE_i),
        .aluSrcE_i    (aluSrcE_i),
        .aluControlE_i(aluControlE_i),
        .forwardAE_i  (forwardAE_i),
        .forwardBE_i  (forwardBE_i),
        .rs1E_o       (rs1E_o),
        .rs2E_o       (rs2E_o),
        .rdE_o        (rdE_o),
        .zeroE_o      (zeroE_o),
        .pcTargetE_o  (pcTargetE),
        .decEx        (decEx.dst),
        .exMem        (exMem.src),
        .wb           (wb.dst)
    );

    memWbStage i_memWbStage (
        .clk         (clk),
        .reset       (reset),
        .readDataM_i (readDataM_i),
        .resultSrcM_i(resultSrcM_i),
        .resultSrcW_i(resultSrcW_i),
        .aluResultM_o(aluResultM_o),
        .writeDataM_o(writeDataM_o),
        .rdM_o       (rdM_o),
        .rdW_o       (rdW_o),
        .exMem       (exMem.dst),
        .wb          (wb.src)
    );

endmodule

/* rtl/memWbStage.sv */
// Execute/memory and memory/writeback registers,
// memory-stage forward select and writeback result select
`timescale 1ns/1ps

module memWbStage (
    input  logic               clk,
    input  logic               reset,
    input  dpPkg::dataWordT    readDataM_i,
    input  dpPkg::resultSrcT   resultSrcM_i,
    input  dpPkg::resultSrcT   resultSrcW_i,
    output dpPkg::dataWordT    aluResultM_o,
    output dpPkg::dataWordT    writeDataM_o,
    output dpPkg::regAddrT     rdM_o,
    output dpPkg::regAddrT     rdW_o,
    exMemIf.dst                exMem,
    wbIf.src                   wb
);
    import dpPkg::*;

    dataWordT immM;
    dataWordT pcPlus4M;
    dataWordT aluResultW;
    dataWordT readDataW;
    dataWordT immW;
    dataWordT pcPlus4W;

    always_ff @(posedge clk) begin
        if (reset) begin
            aluResultM_o <= '0;
            writeDataM_o <= '0;
            immM         <= '0;
            pcPlus4M     <= '0;
            rdM_o        <= '0;
        end else begin
            aluResultM_o <= exMem.aluResult;
            writeDataM_o <= exMem.writeData;
            immM         <= exMem.imm;
            pcPlus4M     <= exMem.pcPlus4;
            rdM_o        <= exMem.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            aluResultW <= '0;
            readDataW  <= '0;
            immW       <= '0;
            pcPlus4W   <= '0;
            rdW_o      <= '0;
        end else begin
            aluResultW <= aluResultM_o;
            readDataW  <= readDataM_i;
            immW       <= immM;
            pcPlus4W   <= pcPlus4M;
            rdW_o      <= rdM_o;
        end
    end

    // Load data is not ready in memory, so it cannot be forwarded from here
    always_comb begin
        case (resultSrcM_i)
            pcPlus4: wb.forwardDataM = pcPlus4M;
            imm:     wb.forwardDataM = immM;
            default: wb.forwardDataM = aluResultM_o;
        endcase
    end

    always_comb begin
        case (resultSrcW_i)
            mem:     wb.resultW = readDataW;
            pcPlus4: wb.resultW = pcPlus4W;  // jal link
            imm:     wb.resultW = immW;      // lui
            default: wb.resultW = aluResultW;
        endcase
    end

    assign wb.aluResultM = aluResultM_o;
    assign wb.rdW        = rdW_o;

endmodule

/* rtl/executeStage.sv */
// Execute stage: decode/execute register, operand forwarding,
// source B select, ALU and branch target
`timescale 1ns/1ps

module executeStage (
    input  logic               clk,
    input  logic               reset,
    input  logic               flushE_i,
    input  dpPkg::srcBSelT     aluSrcE_i,
    input  dpPkg::aluCtrlT     aluControlE_i,
    input  dpPkg::forwardSelT  forwardAE_i,
    input  dpPkg::forwardSelT  forwardBE_i,
    output dpPkg::regAddrT     rs1E_o,
    output dpPkg::regAddrT     rs2E_o,
    output dpPkg::regAddrT     rdE_o,
    output logic               zeroE_o,
    output dpPkg::dataWordT    pcTargetE_o,
    decExIf.dst                decEx,
    exMemIf.src                exMem,
    wbIf.dst                   wb
);
    import dpPkg::*;

    dataWordT rd1E;
    dataWordT rd2E;
    dataWordT pcE;
    dataWordT immE;
    dataWordT pcPlus4E;
    dataWordT srcAE;
    dataWordT srcBE;
    dataWordT writeDataE;
    dataWordT aluResultE;

    // Same selection for both operands, only the memory source differs
    function automatic dataWordT pickOperand(input forwardSelT sel, input dataWordT regVal,
                                             input dataWordT wbVal, input dataWordT memVal);
        case (sel)
            fromWb:  return wbVal;
            fromMem: return memVal;
            default: return regVal;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            rd1E     <= '0;
            rd2E     <= '0;
            pcE      <= '0;
            immE     <= '0;
            pcPlus4E <= '0;
            rs1E_o   <= '0;
            rs2E_o   <= '0;
            rdE_o    <= '0;
        end else begin
            rd1E     <= decEx.rd1;
            rd2E     <= decEx.rd2;
            pcE      <= decEx.pc;
            immE     <= decEx.imm;
            pcPlus4E <= decEx.pcPlus4;
            rs1E_o   <= decEx.rs1;
            rs2E_o   <= decEx.rs2;
            rdE_o    <= decEx.rd;
        end
    end

    assign srcAE      = pickOperand(forwardAE_i, rd1E, wb.resultW, wb.aluResultM);
    assign writeDataE = pickOperand(forwardBE_i, rd2E, wb.resultW, wb.forwardDataM);
    assign srcBE      = (aluSrcE_i == srcImm) ? immE : writeDataE;

    assign pcTargetE_o = pcE + immE; // Branch and jal target

    intAlu i_intAlu (
        .a_i         (srcAE),
        .b_i         (srcBE),
        .aluControl_i(aluControlE_i),
        .result_o    (aluResultE),
        .zero_o      (zeroE_o)
    );

    assign exMem.aluResult = aluResultE;
    assign exMem.writeData = writeDataE;
    assign exMem.pcPlus4   = pcPlus4E;
    assign exMem.imm       = immE;
    assign exMem.rd        = rdE_o;

endmodule

/* rtl/fetchDecode.sv */
// Front end: program counter, fetch/decode register, immediate extension
`timescale 1ns/1ps
`include "dp_settings.svh"

module fetchDecode (
    input  logic              clk,
    input  logic              reset,
    input  logic              stallF_i,
    input  logic              stallD_i,
    input  logic              flushD_i,
    input  logic              pcSrcE_i,
    input  dpPkg::instrWordT  instrF_i,
    input  dpPkg::dataWordT   pcTargetE_i,
    input  dpPkg::immSrcT     immSrcD_i,
    input  dpPkg::dataWordT   rd1_i,
    input  dpPkg::dataWordT   rd2_i,
    output dpPkg::dataWordT   pcF_o,
    output logic [6:0]        op_o,
    output logic [2:0]        funct3_o,
    output logic              funct7b5_o,
    output dpPkg::regAddrT    rs1D_o,
    output dpPkg::regAddrT    rs2D_o,
    decExIf.src               decEx
);
    import dpPkg::*;

    instrWordT instrD;
    dataWordT  pcD;
    dataWordT  pcPlus4D;
    dataWordT  immD;
    dataWordT  pcPlus4F;
    dataWordT  pcNextF;

    assign pcPlus4F = pcF_o + dataWordT'(4);
    assign pcNextF  = pcSrcE_i ? pcTargetE_i : pcPlus4F; // Taken branch from execute

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= `DP_PC_START;
        end else if (!stallF_i) begin
            pcF_o <= pcNextF;
        end
    end

    // Flush wins over stall
    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD   <= `DP_NOP_INSTR;
            pcD      <= '0;
            pcPlus4D <= '0;
        end else if (!stallD_i) begin
            instrD   <= instrF_i;
            pcD      <= pcF_o;
            pcPlus4D <= pcPlus4F;
        end
    end

    assign op_o       = instrD[6:0];
    assign funct3_o   = instrD[14:12];
    assign funct7b5_o = instrD[30];
    assign rs1D_o     = instrD[19:15];
    assign rs2D_o     = instrD[24:20];

    always_comb begin
        case (immSrcD_i)
            immI:    immD = {{20{instrD[31]}}, instrD[31:20]};
            immS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            immJ:    immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            immU:    immD = {instrD[31:12], 12'b0};
            default: immD = '0;
        endcase
    end

    assign decEx.rd1     = rd1_i;
    assign decEx.rd2     = rd2_i;
    assign decEx.pc      = pcD;
    assign decEx.pcPlus4 = pcPlus4D;
    assign decEx.imm     = immD;
    assign decEx.rs1     = rs1D_o;
    assign decEx.rs2     = rs2D_o;
    assign decEx.rd      = instrD[11:7];

endmodule

/* rtl/regFile.sv */
// 32-entry register file, two read ports and one write port
`timescale 1ns/1ps
`include "dp_settings.svh"

module regFile (
    input  logic             clk,
    input  dpPkg::regAddrT   a1_i,
    input  dpPkg::regAddrT   a2_i,
    input  logic             we_i,
    output dpPkg::dataWordT  rd1_o,
    output dpPkg::dataWordT  rd2_o,
    wbIf.dst                 wb
);
    import dpPkg::*;

    dataWordT regs [2**`DP_REG_ADDR_BITS];

    // x0 is hardwired, a same-cycle write is passed straight through
    function automatic dataWordT readPort(input regAddrT addr);
        if (addr == '0) begin
            return '0;
        end else if (we_i && addr == wb.rdW) begin
            return wb.resultW;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (we_i) begin
            regs[wb.rdW] <= wb.resultW;
        end
    end

    always_comb begin
        rd1_o = readPort(a1_i);
        rd2_o = readPort(a2_i);
    end

endmodule

/* rtl/intAlu.sv */
// Integer ALU: add, sub, and, or, signed set-less-than, zero flag
`timescale 1ns/1ps

module intAlu (
    input  dpPkg::dataWordT  a_i,
    input  dpPkg::dataWordT  b_i,
    input  dpPkg::aluCtrlT   aluControl_i,
    output dpPkg::dataWordT  result_o,
    output logic             zero_o
);
    import dpPkg::*;

    always_comb begin
        case (aluControl_i)
            aluAdd:  result_o = a_i + b_i;
            aluSub:  result_o = a_i - b_i;
            aluAnd:  result_o = a_i & b_i;
            aluOr:   result_o = a_i | b_i;
            aluSlt:  result_o = dataWordT'($signed(a_i) < $signed(b_i));
            default: result_o = '0;
        endcase
    end

    // Branch compare uses sub
    assign zero_o = (result_o == '0);

endmodule

/* rtl/dpStageIf.sv */
// Stage-to-stage interfaces: decode to execute, execute to memory,
// and the memory/writeback values used for forwarding and register write
`timescale 1ns/1ps

interface decExIf;
    import dpPkg::*;

    dataWordT rd1;      // Register file read ports
    dataWordT rd2;
    dataWordT pc;
    dataWordT pcPlus4;
    dataWordT imm;      // Extended immediate
    regAddrT  rs1;
    regAddrT  rs2;
    regAddrT  rd;

    modport src (output rd1, rd2, pc, pcPlus4, imm, rs1, rs2, rd);
    modport dst (input  rd1, rd2, pc, pcPlus4, imm, rs1, rs2, rd);
endinterface

interface exMemIf;
    import dpPkg::*;

    dataWordT aluResult;
    dataWordT writeData; // Forwarded B operand, store data
    dataWordT pcPlus4;
    dataWordT imm;
    regAddrT  rd;

    modport src (output aluResult, writeData, pcPlus4, imm, rd);
    modport dst (input  aluResult, writeData, pcPlus4, imm, rd);
endinterface

interface wbIf;
    import dpPkg::*;

    dataWordT aluResultM;
    dataWordT forwardDataM; // Memory-stage forward value
    dataWordT resultW;      // Write data
    regAddrT  rdW;          // Write address

    modport src (output aluResultM, forwardDataM, resultW, rdW);
    modport dst (input  aluResultM, forwardDataM, resultW, rdW);
endinterface

/* rtl/dpPkg.sv */
// Datapath types: data, instruction and register index words
// Select codes for immediate format, ALU op, forwarding, source B and result
package dpPkg;

    `include "dp_settings.svh"

    typedef logic [`DP_XLEN-1:0]          dataWordT;  // Data or PC word
    typedef logic [31:0]                  instrWordT;
    typedef logic [`DP_REG_ADDR_BITS-1:0] regAddrT;

    // Immediate formats
    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immJ = 3'b011,
        immU = 3'b100
    } immSrcT;

    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101  // Signed compare
    } aluCtrlT;

    // Operand forwarding into execute
    typedef enum logic [1:0] {
        regFile = 2'b00,
        fromWb  = 2'b01,
        fromMem = 2'b10
    } forwardSelT;

    typedef enum logic {
        srcReg = 1'b0,
        srcImm = 1'b1
    } srcBSelT;

    // Writeback result, also the memory-stage forward value
    typedef enum logic [1:0] {
        aluOut  = 2'b00,
        mem     = 2'b01,
        pcPlus4 = 2'b10,
        imm     = 2'b11
    } resultSrcT;

endpackage

/* rtl/dp_settings.svh */
// Datapath widths, reset PC and the decode NOP encoding
`ifndef DP_SETTINGS_SVH
`define DP_SETTINGS_SVH

// Data and address width
`define DP_XLEN          32

// Register index width, 32 architectural registers
`define DP_REG_ADDR_BITS 5

// First fetch address after reset
`define DP_PC_START      32'h0000_0000

// Loaded into decode on a flush
`define DP_NOP_INSTR     32'h0000_0013 // addi x0, x0, 0

`endif
